// File: fetch_addr_gen.sv
`timescale 1ns/1ps

module fetch_addr_gen (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [fetch_pkg::ADDR_W-1:0] init_addr_i,
    input  logic                         is_init_i,
    input  logic                         is_resteer_i,
    input  logic                         is_br_taken_i,
    input  logic [fetch_pkg::FIP_W-1:0]  bp_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]  bp_fip_odd_i,
    input  logic [fetch_pkg::FIP_W-1:0]  wb_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]  wb_fip_odd_i,
    input  logic                         even_ld_i,
    input  logic                         odd_ld_i,
    output logic [fetch_pkg::FIP_W-1:0]  fip_even_o,
    output logic [fetch_pkg::FIP_W-1:0]  fip_odd_o
);

    fetch_pkg::cf_src_e          cf_src;
    logic [fetch_pkg::FIP_W-1:0] init_line;
    logic [fetch_pkg::FIP_W-1:0] init_line_p1;
    logic [fetch_pkg::FIP_W-1:0] init_even;
    logic [fetch_pkg::FIP_W-1:0] init_odd;

    // init > resteer > branch
    always_comb begin
        if (is_init_i) begin
            cf_src = fetch_pkg::CF_INIT;
        end else if (is_resteer_i) begin
            cf_src = fetch_pkg::CF_RESTEER;
        end else if (is_br_taken_i) begin
            cf_src = fetch_pkg::CF_BRANCH;
        end else begin
            cf_src = fetch_pkg::CF_NONE;
        end
    end

    ////////////////////
    // init split, line and line + 1 go to whichever bank owns them
    assign init_line    = init_addr_i[fetch_pkg::ADDR_W-1:fetch_pkg::OFFSET_W];
    assign init_line_p1 = init_line + 1'b1;
    assign init_even    = init_addr_i[fetch_pkg::OFFSET_W] ? init_line_p1 : init_line;
    assign init_odd     = init_addr_i[fetch_pkg::OFFSET_W] ? init_line : init_line_p1;

    fip_select sel_even (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cf_src_i   (cf_src),
        .init_fip_i (init_even),
        .bp_fip_i   (bp_fip_even_i),
        .wb_fip_i   (wb_fip_even_i),
        .ld_i       (even_ld_i),
        .fip_o      (fip_even_o)
    );

    fip_select sel_odd (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cf_src_i   (cf_src),
        .init_fip_i (init_odd),
        .bp_fip_i   (bp_fip_odd_i),
        .wb_fip_i   (wb_fip_odd_i),
        .ld_i       (odd_ld_i),
        .fip_o      (fip_odd_o)
    );

    ////////////////////
    // checks

    icache_pkg::line_addr_u even_addr;
    icache_pkg::line_addr_u odd_addr;

    assign even_addr.line = fip_even_o;
    assign odd_addr.line  = fip_odd_o;

    // registered pointers keep their bank after a redirect
    a_bank_parity: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (cf_src != fetch_pkg::CF_NONE) |=> (!even_addr.f.bank && odd_addr.f.bank)
    ) else $error("fetch pointer landed in the wrong bank");

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

    ////////////////////
    // address widths

    localparam int ADDR_W   = 32;          // byte address
    localparam int OFFSET_W = 4;           // 16-byte line
    localparam int FIP_W    = ADDR_W - OFFSET_W;

    // each bank holds every other line
    localparam logic [FIP_W-1:0] FIP_STEP = 2;

    ////////////////////
    // next-pointer source, highest priority last

    typedef enum logic [1:0] {
        CF_NONE    = 2'd0,    // hold or advance
        CF_BRANCH  = 2'd1,    // predicted taken branch
        CF_RESTEER = 2'd2,    // writeback redirect
        CF_INIT    = 2'd3     // start-up / init address
    } cf_src_e;

endpackage

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [fetch_pkg::ADDR_W-1:0]  init_addr_i,
    input  logic                          is_init_i,
    input  logic                          is_resteer_i,
    input  logic                          is_br_taken_i,
    input  logic [fetch_pkg::FIP_W-1:0]   bp_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]   bp_fip_odd_i,
    input  logic [fetch_pkg::FIP_W-1:0]   wb_fip_even_i,
    input  logic [fetch_pkg::FIP_W-1:0]   wb_fip_odd_i,
    input  logic                          even_latch_loaded_i,
    input  logic                          odd_latch_loaded_i,
    output logic [icache_pkg::LINE_W-1:0] even_line_o,
    output logic [icache_pkg::LINE_W-1:0] odd_line_o,
    output logic                          cache_miss_even_o,
    output logic                          cache_miss_odd_o,
    output logic [1:0]                    fip_even_lsb_o,
    output logic [1:0]                    fip_odd_lsb_o,
    output logic                          mem_req_o,
    output logic [fetch_pkg::FIP_W-1:0]   mem_addr_o,
    input  logic                          mem_fill_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_fill_data_i
);

    logic [fetch_pkg::FIP_W-1:0] fip_even;
    logic [fetch_pkg::FIP_W-1:0] fip_odd;

    icache_fill_if fill_even ();
    icache_fill_if fill_odd ();

    fetch_addr_gen addr_gen (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .init_addr_i   (init_addr_i),
        .is_init_i     (is_init_i),
        .is_resteer_i  (is_resteer_i),
        .is_br_taken_i (is_br_taken_i),
        .bp_fip_even_i (bp_fip_even_i),
        .bp_fip_odd_i  (bp_fip_odd_i),
        .wb_fip_even_i (wb_fip_even_i),
        .wb_fip_odd_i  (wb_fip_odd_i),
        .even_ld_i     (even_latch_loaded_i),
        .odd_ld_i      (odd_latch_loaded_i),
        .fip_even_o    (fip_even),
        .fip_odd_o     (fip_odd)
    );

    assign fip_even_lsb_o = fip_even[1:0];   // address bits 5:4
    assign fip_odd_lsb_o  = fip_odd[1:0];

    ////////////////////
    // banks and shared refill

    icache_bank bank_even (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fip_i   (fip_even),
        .line_o  (even_line_o),
        .miss_o  (cache_miss_even_o),
        .fill    (fill_even.bank)
    );

    icache_bank bank_odd (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fip_i   (fip_odd),
        .line_o  (odd_line_o),
        .miss_o  (cache_miss_odd_o),
        .fill    (fill_odd.bank)
    );

    icache_refill refill (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .even             (fill_even.refill),
        .odd              (fill_odd.refill),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_fill_valid_i (mem_fill_valid_i),
        .mem_fill_data_i  (mem_fill_data_i)
    );

endmodule

// File: fip_select.sv
`timescale 1ns/1ps

module fip_select (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  fetch_pkg::cf_src_e          cf_src_i,
    input  logic [fetch_pkg::FIP_W-1:0] init_fip_i,
    input  logic [fetch_pkg::FIP_W-1:0] bp_fip_i,
    input  logic [fetch_pkg::FIP_W-1:0] wb_fip_i,
    input  logic                        ld_i,
    output logic [fetch_pkg::FIP_W-1:0] fip_o
);

    logic [fetch_pkg::FIP_W-1:0] fip_q;    // pointer register
    logic [fetch_pkg::FIP_W-1:0] sel_fip;  // bypassed pointer

    // control flow bypasses the register in its own cycle
    always_comb begin
        case (cf_src_i)
            fetch_pkg::CF_INIT:    sel_fip = init_fip_i;
            fetch_pkg::CF_RESTEER: sel_fip = wb_fip_i;
            fetch_pkg::CF_BRANCH:  sel_fip = bp_fip_i;
            default:               sel_fip = fip_q;
        endcase
    end

    assign fip_o = sel_fip;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fip_q <= '0;
        end else if (cf_src_i != fetch_pkg::CF_NONE) begin
            fip_q <= sel_fip;                        // keep the redirect target
        end else if (ld_i) begin
            fip_q <= fip_q + fetch_pkg::FIP_STEP;    // next line of this bank
        end
    end

    ////////////////////
    // checks

    // pointer only moves on a strobe or a redirect
    a_hold_without_ld: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (!ld_i && cf_src_i == fetch_pkg::CF_NONE) |=> $stable(fip_q)
    ) else $error("fip register moved without ld or control flow");

endmodule

// File: icache_bank.sv
`timescale 1ns/1ps

module icache_bank (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [fetch_pkg::FIP_W-1:0]   fip_i,
    output logic [icache_pkg::LINE_W-1:0] line_o,
    output logic                          miss_o,
    icache_fill_if.bank                   fill
);

    icache_pkg::line_addr_u addr;

    logic [icache_pkg::TAG_W-1:0]  tag_mem  [icache_pkg::SETS];
    logic [icache_pkg::LINE_W-1:0] data_mem [icache_pkg::SETS];
    logic [icache_pkg::SETS-1:0]   valid_q;

    logic tag_eq;
    logic hit;

    assign addr.line = fip_i;

    ////////////////////
    // lookup, fully combinational

    assign tag_eq = (tag_mem[addr.f.index] == addr.f.tag);
    assign hit    = valid_q[addr.f.index] && tag_eq;
    assign line_o = data_mem[addr.f.index];   // only meaningful on a hit
    assign miss_o = !hit;

    // refill side sees the same pointer
    assign fill.miss      = !hit;
    assign fill.miss_addr = fip_i;

    ////////////////////
    // fill write

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill.fill_we) begin
            valid_q[addr.f.index] <= 1'b1;
        end
    end

    // refill only fires while this pointer still misses at the served line
    always_ff @(posedge clk) begin
        if (fill.fill_we) begin
            tag_mem[addr.f.index]  <= addr.f.tag;
            data_mem[addr.f.index] <= fill.fill_data;
        end
    end

    ////////////////////
    // checks

    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fill.fill_we |-> fill.miss
    ) else $error("fill_we without an open miss");

    // a fill must turn the same pointer into a hit
    a_fill_hits: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fill.fill_we |=> ($changed(fip_i) || !miss_o)
    ) else $error("line still misses after its fill");

endmodule

// File: icache_fill_if.sv
`timescale 1ns/1ps

// miss / fill path between one bank and the shared refill unit
interface icache_fill_if;

    logic                          miss;       // level, held while no hit
    logic [fetch_pkg::FIP_W-1:0]   miss_addr;  // the bank's current pointer

    logic                          fill_we;    // single cycle
    logic [icache_pkg::LINE_W-1:0] fill_data;

    modport bank (
        output miss,
        output miss_addr,
        input  fill_we,
        input  fill_data
    );

    modport refill (
        input  miss,
        input  miss_addr,
        output fill_we,
        output fill_data
    );

endinterface

// File: icache_pkg.sv
package icache_pkg;

    ////////////////////
    // bank geometry

    localparam int LINE_W  = 128;
    localparam int SETS    = 16;           // per bank
    localparam int INDEX_W = 4;

    // line number minus index and bank bit
    localparam int TAG_W = fetch_pkg::FIP_W - INDEX_W - 1;

    ////////////////////
    // one fetch pointer, seen as a raw line number or split into fields
    // bank is line bit 0, index sits right above it

    typedef union packed {
        logic [fetch_pkg::FIP_W-1:0] line;     // sent out as memory address
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic               bank;          // 0 even, 1 odd
        } f;
    } line_addr_u;

endpackage

// File: icache_refill.sv
`timescale 1ns/1ps

module icache_refill (
    input  logic                          clk,
    input  logic                          rst_n_i,
    icache_fill_if.refill                 even,
    icache_fill_if.refill                 odd,
    output logic                          mem_req_o,
    output logic [fetch_pkg::FIP_W-1:0]   mem_addr_o,
    input  logic                          mem_fill_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] mem_fill_data_i
);

    logic                        busy_q;   // idle / busy
    logic                        odd_q;    // bank being served
    logic [fetch_pkg::FIP_W-1:0] addr_q;   // latched miss line
    logic                        start;
    logic                        even_match;
    logic                        odd_match;

    assign start = !busy_q && (even.miss || odd.miss);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            odd_q  <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
            odd_q  <= !even.miss;      // even wins a tie
        end else if (busy_q && mem_fill_valid_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= even.miss ? even.miss_addr : odd.miss_addr;
        end
    end

    assign mem_req_o  = busy_q;
    assign mem_addr_o = addr_q;

    ////////////////////
    // fill steering
    // drop the fill if the bank was redirected away meanwhile
    assign even_match = even.miss && (even.miss_addr == addr_q);
    assign odd_match  = odd.miss && (odd.miss_addr == addr_q);

    assign even.fill_we   = busy_q && !odd_q && mem_fill_valid_i && even_match;
    assign odd.fill_we    = busy_q && odd_q && mem_fill_valid_i && odd_match;
    assign even.fill_data = mem_fill_data_i;   // write enable decides who takes it
    assign odd.fill_data  = mem_fill_data_i;

    ////////////////////
    // checks

    a_fill_in_req: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        mem_fill_valid_i |-> mem_req_o
    ) else $error("fill pulse with no request open");

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (mem_req_o && !mem_fill_valid_i) |=> $stable(mem_addr_o)
    ) else $error("mem_addr_o moved during a request");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_top -f sources.f \
    && ./obj_dir/Vtb_fetch_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "compile or run error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation clean"
exit 0

// File: sources.f
fetch_pkg.sv
icache_pkg.sv
icache_fill_if.sv
fip_select.sv
fetch_addr_gen.sv
icache_bank.sv
icache_refill.sv
fetch_top.sv
tb_fetch_top.sv

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

    localparam int FW          = fetch_pkg::FIP_W;
    localparam int N_TESTS     = 6;
    localparam int ACCESSES    = 40;           // per test
    localparam int MAX_FILL    = 4;            // worst memory latency, cycles
    localparam int TIMEOUT_CYC =
        ((N_TESTS * ACCESSES * (MAX_FILL + 2) * 2) / 1000 + 1) * 1000;
    localparam logic [FW-1:0] LINE_STEP = 2;   // a bank owns every other line

    logic                          clk = 1'b0;
    logic                          rst_n_i;
    logic [31:0]                   init_addr_i;
    logic                          is_init_i;
    logic                          is_resteer_i;
    logic                          is_br_taken_i;
    logic [FW-1:0]                 bp_fip_even_i;
    logic [FW-1:0]                 bp_fip_odd_i;
    logic [FW-1:0]                 wb_fip_even_i;
    logic [FW-1:0]                 wb_fip_odd_i;
    logic                          even_latch_loaded_i;
    logic                          odd_latch_loaded_i;
    logic [icache_pkg::LINE_W-1:0] even_line_o;
    logic [icache_pkg::LINE_W-1:0] odd_line_o;
    logic                          cache_miss_even_o;
    logic                          cache_miss_odd_o;
    logic [1:0]                    fip_even_lsb_o;
    logic [1:0]                    fip_odd_lsb_o;
    logic                          mem_req_o;
    logic [FW-1:0]                 mem_addr_o;
    logic                          mem_fill_valid_i;
    logic [icache_pkg::LINE_W-1:0] mem_fill_data_i;

    logic [FW-1:0] reg_even;    // expected pointer registers
    logic [FW-1:0] reg_odd;
    logic [FW-1:0] prev_even;   // expected pointers one cycle back
    logic [FW-1:0] prev_odd;
    logic          prev_miss_even;
    logic          prev_miss_odd;
    logic          prev_req;
    integer        seed;
    int            err_count    = 0;
    int            req_count    = 0;
    int            cycles       = 0;
    int            test_num     = 0;
    int            tests_failed = 0;

    fetch_top fetch_top_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////
    // reference model

    // four tagged copies of the line number
    function automatic logic [127:0] line_data(input logic [FW-1:0] fip);
        logic [31:0] w;
        w = {4'h0, fip};
        return {w ^ 32'h5a5a_0f0f, w ^ 32'hc3c3_1234, w ^ 32'h0ff0_a5a5, w ^ 32'h9669_7e7e};
    endfunction

    // {even, odd} pointers seen this cycle
    function automatic logic [2*FW-1:0] exp_pointers(
        input logic [31:0]   addr,
        input logic          init,
        input logic          resteer,
        input logic          branch,
        input logic [FW-1:0] bp_e, bp_o, wb_e, wb_o, cur_e, cur_o
    );
        logic [FW-1:0] line;
        line = addr[31:4];
        if (init) begin
            if (addr[4])
                return {line + 1'b1, line};   // odd line first
            return {line, line + 1'b1};
        end
        if (resteer)
            return {wb_e, wb_o};
        if (branch)
            return {bp_e, bp_o};
        return {cur_e, cur_o};
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        err_count++;
    endtask

    task automatic report_text(input string msg);
        $display("error: %s", msg);
        err_count++;
    endtask

    ////////////////////
    // compare, sampled mid-cycle

    always @(negedge clk) begin : compare
        logic [2*FW-1:0] exp_fips;
        logic [FW-1:0]   exp_even;
        logic [FW-1:0]   exp_odd;
        if (!rst_n_i) begin
            reg_even = '0;
            reg_odd  = '0;
            exp_even = '0;
            exp_odd  = '0;
        end else begin
            exp_fips = exp_pointers(init_addr_i, is_init_i, is_resteer_i, is_br_taken_i,
                                    bp_fip_even_i, bp_fip_odd_i, wb_fip_even_i, wb_fip_odd_i,
                                    reg_even, reg_odd);
            exp_even = exp_fips[2*FW-1:FW];
            exp_odd  = exp_fips[FW-1:0];
            assert (fip_even_lsb_o == exp_even[1:0])
                else report_value("fip_even_lsb_o", fip_even_lsb_o, exp_even[1:0]);
            assert (fip_odd_lsb_o == exp_odd[1:0])
                else report_value("fip_odd_lsb_o", fip_odd_lsb_o, exp_odd[1:0]);
            if (!cache_miss_even_o)
                assert (even_line_o == line_data(exp_even))
                    else report_value("even_line_o", even_line_o, line_data(exp_even));
            if (!cache_miss_odd_o)
                assert (odd_line_o == line_data(exp_odd))
                    else report_value("odd_line_o", odd_line_o, line_data(exp_odd));
            // new request, even bank wins a tie
            if (mem_req_o && !prev_req) begin
                req_count++;
                assert (prev_miss_even || prev_miss_odd)
                    else report_text("memory request raised while both banks hit");
                assert (mem_addr_o == (prev_miss_even ? prev_even : prev_odd))
                    else report_value("mem_addr_o", mem_addr_o,
                                      prev_miss_even ? prev_even : prev_odd);
            end
            if (is_init_i || is_resteer_i || is_br_taken_i) begin
                reg_even = exp_even;
                reg_odd  = exp_odd;
            end else begin
                if (even_latch_loaded_i)
                    reg_even = reg_even + LINE_STEP;
                if (odd_latch_loaded_i)
                    reg_odd = reg_odd + LINE_STEP;
            end
        end
        prev_even      = exp_even;
        prev_odd       = exp_odd;
        prev_miss_even = cache_miss_even_o;
        prev_miss_odd  = cache_miss_odd_o;
        prev_req       = mem_req_o;
    end

    // memory, answers after 1 to MAX_FILL cycles
    always begin : mem_model
        int   delay;
        logic abort;
        @(negedge clk);
        if (rst_n_i && mem_req_o) begin
            delay = 1 + ($unsigned($random(seed)) % MAX_FILL);
            abort = 1'b0;
            repeat (delay) begin
                @(posedge clk);
                if (!rst_n_i)
                    abort = 1'b1;   // request died in reset
            end
            #2;
            if (!abort && rst_n_i && mem_req_o) begin
                mem_fill_valid_i = 1'b1;
                mem_fill_data_i  = line_data(mem_addr_o);
                @(posedge clk);
                #2;
                mem_fill_valid_i = 1'b0;
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_hits();
        while (cache_miss_even_o || cache_miss_odd_o)
            step();
    endtask

    task automatic pulse_init(input logic [31:0] addr);
        init_addr_i = addr;
        is_init_i   = 1'b1;
        step();
        is_init_i = 1'b0;
    endtask

    task automatic end_test(input string name, input int first_err);
        test_num++;
        if (err_count == first_err) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", test_num, name, err_count - first_err);
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          base;
        int          start;
        seed                = 32'h7098fe64;
        rst_n_i             = 1'b0;
        init_addr_i         = '0;
        is_init_i           = 1'b0;
        is_resteer_i        = 1'b0;
        is_br_taken_i       = 1'b0;
        bp_fip_even_i       = '0;
        bp_fip_odd_i        = '0;
        wb_fip_even_i       = '0;
        wb_fip_odd_i        = '0;
        even_latch_loaded_i = 1'b0;
        odd_latch_loaded_i  = 1'b0;
        mem_fill_valid_i    = 1'b0;
        mem_fill_data_i     = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n_i = 1'b1;

        // both pointers sit on line 0, each bank fetches it once
        start = err_count;
        wait_hits();
        assert (req_count == 2) else report_value("req_count", req_count, 2);
        end_test("reset fill", start);

        start = err_count;
        pulse_init(32'h0000_1230);   // bit 4 set
        wait_hits();
        pulse_init(32'h0000_4560);
        wait_hits();
        end_test("init split", start);

        start = err_count;
        repeat (ACCESSES) begin
            r = $random(seed);
            even_latch_loaded_i = r[0] && !cache_miss_even_o;
            odd_latch_loaded_i  = r[1] && !cache_miss_odd_o;
            step();
        end
        even_latch_loaded_i = 1'b0;
        odd_latch_loaded_i  = 1'b0;
        wait_hits();
        end_test("random loads", start);

        // every mix of init, resteer and branch, then a hold cycle
        start = err_count;
        for (int k = 0; k < 8; k++) begin
            init_addr_i   = 32'h0001_0000 + k * 32'h208;
            bp_fip_even_i = FW'(32'h2000 + 4 * k);
            bp_fip_odd_i  = bp_fip_even_i + 1'b1;
            wb_fip_even_i = FW'(32'h3000 + 4 * k);
            wb_fip_odd_i  = wb_fip_even_i + 1'b1;
            is_init_i     = k[0];
            is_resteer_i  = k[1];
            is_br_taken_i = k[2];
            step();
            is_init_i     = 1'b0;
            is_resteer_i  = 1'b0;
            is_br_taken_i = 1'b0;
            wait_hits();
            step();
        end
        end_test("priority", start);

        start = err_count;
        base  = req_count;
        pulse_init(32'h0008_0000);
        wait_hits();
        pulse_init(32'h0008_0040);   // other index, keeps the first lines
        wait_hits();
        pulse_init(32'h0008_0000);
        wait_hits();
        assert (req_count == base + 4) else report_value("req_count", req_count, base + 4);
        end_test("refill rules", start);

        start = err_count;
        pulse_init(32'h0009_0020);   // nonzero low bits in both pointers
        while (!mem_req_o)
            step();
        rst_n_i = 1'b0;
        @(negedge clk);
        assert (!mem_req_o) else report_value("mem_req_o", mem_req_o, 0);
        assert (fip_even_lsb_o == 2'd0 && fip_odd_lsb_o == 2'd0)
            else report_text("pointers not cleared by reset");
        step();
        step();
        rst_n_i = 1'b1;
        step();
        init_addr_i = 32'h0008_0000;
        is_init_i   = 1'b1;
        @(negedge clk);
        assert (cache_miss_even_o && cache_miss_odd_o)
            else report_text("line filled before reset still hits");
        step();
        is_init_i = 1'b0;
        wait_hits();
        end_test("mid-run reset", start);

        $display("tests run %0d, failed %0d, errors %0d, memory requests %0d",
                 test_num, tests_failed, err_count, req_count);
        if (err_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
